// ==== bench/tb_camera_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_camera_capture;
    import cam_pkg::*;
    import fb_pkg::*;

    localparam int N_FRAMES = 2;
    localparam logic [31:0] SEED = 32'h95bd;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    localparam int PCLK_MAX = 4;        // longest pclk level in cycles
    localparam int GAP_MAX = 9;         // junk bytes in one hsync gap
    localparam int VS_BYTES = 8;        // junk bytes while vsync is low
    localparam int TRAIL_BYTES = 2;
    localparam int LINE_BYTES_MAX = 2 * CAM_W + GAP_MAX;
    localparam int FRAME_CYCLES_MAX =
        (CAM_H * LINE_BYTES_MAX + VS_BYTES + TRAIL_BYTES) * 2 * PCLK_MAX;
    localparam int READ_WAIT_MAX = 16;  // cycles to wait for rd_valid
    localparam int READ_CYCLES_MAX = READ_WAIT_MAX + 4;
    localparam int N_STREAM_READS = 40;
    localparam int FLUSH_CYCLES = 8;    // sync, edge detect, pixel and write stages
    localparam int WATCHDOG_CYCLES =
        2 * (N_FRAMES * FRAME_CYCLES_MAX + 4 * FB_DEPTH * READ_CYCLES_MAX) + 1000;

    logic       clk_camera;
    logic       recent_reset;
    cam_byte_t  camera_d;
    logic       cam_pclk, cam_hsync, cam_vsync;
    logic       rd_req;
    fb_x_t      rd_x;
    fb_y_t      rd_y;
    chan_sel_t  chan_sel;
    logic [7:0] lower_bound, upper_bound;
    logic       rd_valid;
    pixel565_t  rd_pixel;
    logic       rd_mask;

    logic [31:0] lfsr_state;
    logic        read_active = 1'b0;  // a host read is between rd_req and its pulse
    pixel565_t   model [FB_DEPTH];    // expected frame buffer contents

    // reads issued while the second frame streams in
    fb_x_t      s_x [N_STREAM_READS];
    fb_y_t      s_y [N_STREAM_READS];
    chan_sel_t  s_sel [N_STREAM_READS];
    logic [7:0] s_lo [N_STREAM_READS];
    logic [7:0] s_hi [N_STREAM_READS];
    int         s_gap [N_STREAM_READS];

    tb_clock i_tb_clock (.clk_camera(clk_camera), .recent_reset(recent_reset));

    camera_capture_top i_camera_capture_top (
        .clk_camera(clk_camera), .recent_reset(recent_reset),
        .camera_d(camera_d), .cam_pclk(cam_pclk),
        .cam_hsync(cam_hsync), .cam_vsync(cam_vsync),
        .rd_req(rd_req), .rd_x(rd_x), .rd_y(rd_y), .chan_sel(chan_sel),
        .lower_bound(lower_bound), .upper_bound(upper_bound),
        .rd_valid(rd_valid), .rd_pixel(rd_pixel), .rd_mask(rd_mask)
    );

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s actual 0x%0h expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_camera);
    endtask

    // one byte with random pclk low and high times of 2 to 4 cycles
    task automatic drive_byte(input cam_byte_t b);
        int lo_len;
        int hi_len;
        lo_len = 2 + int'(rand_bits(2)) % 3;
        hi_len = 2 + int'(rand_bits(2)) % 3;
        camera_d = b;
        cam_pclk = 1'b0;
        wait_cycles(lo_len);
        cam_pclk = 1'b1;  // byte taken on this rise
        wait_cycles(hi_len);
    endtask

    task automatic drive_junk(input int n);
        repeat (n) drive_byte(cam_byte_t'(rand_bits(8)));
    endtask

    // downsample rule, keep columns and rows on the 4 by 4 grid
    task automatic record_pixel(input int col, input int row, input pixel565_t p);
        fb_addr_t a;
        if (col % (1 << DS_SHIFT) == 0 && row % (1 << DS_SHIFT) == 0) begin
            a = fb_addr_t'((col >> DS_SHIFT) + FB_W * (row >> DS_SHIFT));
            model[a] = p;
        end
    endtask

    task automatic drive_frame();
        int gap;
        pixel565_t p;
        cam_vsync = 1'b0;
        cam_hsync = 1'b1;  // hsync high alone must not start a line
        drive_junk(VS_BYTES / 2);
        cam_hsync = 1'b0;
        drive_junk(VS_BYTES / 2);
        cam_vsync = 1'b1;
        for (int row = 0; row < CAM_H; row++) begin
            cam_hsync = 1'b0;
            gap = 2 + int'(rand_bits(3));
            drive_junk(gap);  // blanking bytes are ignored
            cam_hsync = 1'b1;
            for (int col = 0; col < CAM_W; col++) begin
                p = pixel565_t'(rand_bits(16));
                drive_byte(p[15:8]);  // high byte first
                drive_byte(p[7:0]);
                record_pixel(col, row, p);
            end
        end
        cam_hsync = 1'b0;
        drive_junk(TRAIL_BYTES);
    endtask

    function automatic logic expected_mask(input pixel565_t p, input chan_sel_t sel,
                                           input logic [7:0] lo, input logic [7:0] hi);
        logic [7:0] v;
        case (sel)
            CH_RED:  v = {p[15:11], 3'b000};
            CH_BLUE: v = {p[4:0], 3'b000};
            default: v = {p[10:5], 2'b00};  // green, and code 3
        endcase
        return (lo <= v) && (v <= hi);
    endfunction

    // one host read, waits for its rd_valid and checks that it is a single pulse
    task automatic read_pixel(input fb_x_t x, input fb_y_t y, input chan_sel_t sel,
                              input logic [7:0] lo, input logic [7:0] hi,
                              output pixel565_t pixel, output logic mask);
        int waited;
        rd_x = x;
        rd_y = y;
        chan_sel = sel;
        lower_bound = lo;
        upper_bound = hi;
        read_active = 1'b1;
        rd_req = 1'b1;
        @(negedge clk_camera);
        rd_req = 1'b0;
        waited = 0;
        while (rd_valid !== 1'b1) begin
            if (waited == READ_WAIT_MAX) begin
                abort_run($sformatf("read of x %0d y %0d got no rd_valid in %0d cycles",
                                    x, y, READ_WAIT_MAX));
            end
            @(negedge clk_camera);
            waited++;
        end
        pixel = rd_pixel;
        mask = rd_mask;
        @(negedge clk_camera);
        check_value("rd_valid", 32'(rd_valid), 32'h0);
        read_active = 1'b0;
    endtask

    task automatic readback_all();
        pixel565_t  got;
        logic       m;
        chan_sel_t  sel;
        logic [7:0] lo, hi;
        fb_addr_t   a;
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                sel = chan_sel_t'(rand_bits(2));
                lo = 8'(rand_bits(7));
                hi = 8'(int'(lo) + int'(rand_bits(7)));  // window above lo
                a = fb_addr_t'(x + FB_W * y);
                read_pixel(fb_x_t'(x), fb_y_t'(y), sel, lo, hi, got, m);
                check_value($sformatf("rd_pixel[%0d]", a), 32'(got), 32'(model[a]));
                check_value($sformatf("rd_mask[%0d]", a), 32'(m),
                            32'(expected_mask(model[a], sel, lo, hi)));
            end
        end
    endtask

    // drawn up front so the two streams share no random draws
    task automatic plan_stream_reads();
        for (int i = 0; i < N_STREAM_READS; i++) begin
            s_x[i] = fb_x_t'(rand_bits(4));
            s_y[i] = fb_y_t'(rand_bits(3));
            s_sel[i] = chan_sel_t'(rand_bits(2));
            s_lo[i] = 8'(rand_bits(8));
            s_hi[i] = 8'(rand_bits(8));
            s_gap[i] = 20 + int'(rand_bits(6));
        end
    endtask

    task automatic stream_reads();
        pixel565_t got;
        logic      m;
        for (int i = 0; i < N_STREAM_READS; i++) begin
            wait_cycles(s_gap[i]);
            read_pixel(s_x[i], s_y[i], s_sel[i], s_lo[i], s_hi[i], got, m);
        end
    endtask

    // rd_valid only ever answers a request
    always @(negedge clk_camera) begin
        if (recent_reset === 1'b0 && !read_active) begin
            check_value("rd_valid", 32'(rd_valid), 32'h0);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_camera);
        abort_run($sformatf("timeout, tests still running after %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin
        pixel565_t got;
        logic      m;
        lfsr_state = SEED;
        camera_d = '0;
        cam_pclk = 1'b0;
        cam_hsync = 1'b0;
        cam_vsync = 1'b0;
        rd_req = 1'b0;
        rd_x = '0;
        rd_y = '0;
        chan_sel = CH_GREEN;
        lower_bound = '0;
        upper_bound = '0;
        @(posedge clk_camera);
        while (recent_reset !== 1'b0) @(posedge clk_camera);
        @(negedge clk_camera);

        // idle after reset, then a single read before any frame
        repeat (20) begin
            check_value("rd_valid", 32'(rd_valid), 32'h0);
            @(negedge clk_camera);
        end
        read_pixel('0, '0, CH_GREEN, 8'h00, 8'hff, got, m);  // memory still unwritten

        drive_frame();
        wait_cycles(FLUSH_CYCLES);
        readback_all();

        plan_stream_reads();
        fork
            drive_frame();
            stream_reads();
        join
        wait_cycles(FLUSH_CYCLES);
        readback_all();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_camera,
    output logic recent_reset
);
    localparam int HALF_PERIOD = 2;   // 4 ns period
    localparam int RESET_CYCLES = 10;

    initial begin
        clk_camera = 1'b0;
        forever #(HALF_PERIOD) clk_camera = ~clk_camera;
    end

    initial begin
        recent_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_camera);
        @(negedge clk_camera);
        recent_reset = 1'b0;  // released between edges
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/cam_pkg.sv
src/fb_pkg.sv
src/pixel_reconstruct.sv
src/downsample_writer.sv
src/fb_arbiter.sv
src/frame_buffer.sv
src/pixel_reader.sv
src/camera_capture_top.sv
bench/tb_clock.sv
bench/tb_camera_capture.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the camera capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_camera_capture -Mdir obj_dir -f compile.f

# the simulator exits non-zero on a failure, the search below decides
output="$(./obj_dir/Vtb_camera_capture 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== src/cam_pkg.sv ====
`default_nettype none

// camera side of the capture path
package cam_pkg;

    localparam int CAM_W = 64;  // active pixels per line
    localparam int CAM_H = 32;  // active lines per frame

    // rgb565 field positions
    localparam int R_MSB = 15;
    localparam int R_LSB = 11;
    localparam int G_MSB = 10;
    localparam int G_LSB = 5;
    localparam int B_MSB = 4;
    localparam int B_LSB = 0;

    typedef logic [$clog2(CAM_W)-1:0] hcount_t;  // camera column
    typedef logic [$clog2(CAM_H)-1:0] vcount_t;  // camera row

    typedef logic [15:0] pixel565_t;  // r g b packed msb first
    typedef logic [7:0] cam_byte_t;   // one byte off the camera bus

endpackage

`default_nettype wire

// ==== src/camera_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module camera_capture_top (
    input  wire                clk_camera,
    input  wire                recent_reset,
    // camera bus, asynchronous levels
    input  wire cam_pkg::cam_byte_t camera_d,
    input  wire                cam_pclk,
    input  wire                cam_hsync,
    input  wire                cam_vsync,
    // host readout port
    input  wire                rd_req,
    input  wire fb_pkg::fb_x_t rd_x,
    input  wire fb_pkg::fb_y_t rd_y,
    input  wire fb_pkg::chan_sel_t chan_sel,
    input  wire [7:0]          lower_bound,
    input  wire [7:0]          upper_bound,
    output logic               rd_valid,
    output cam_pkg::pixel565_t rd_pixel,
    output logic               rd_mask
);
    import cam_pkg::*;
    import fb_pkg::*;

    logic      pix_valid;
    pixel565_t pix_data;
    hcount_t   pix_hcount;
    vcount_t   pix_vcount;

    logic      wr_en;
    fb_addr_t  wr_addr;
    pixel565_t wr_data;

    logic      rd_pend, rd_grant;
    fb_addr_t  rd_addr;

    logic      mem_we;
    fb_addr_t  mem_addr;
    pixel565_t mem_wdata, mem_rdata;

    pixel_reconstruct i_pixel_reconstruct (
        .clk_camera(clk_camera), .recent_reset(recent_reset),
        .camera_d(camera_d), .cam_pclk(cam_pclk),
        .cam_hsync(cam_hsync), .cam_vsync(cam_vsync),
        .pix_valid(pix_valid), .pix_data(pix_data),
        .pix_hcount(pix_hcount), .pix_vcount(pix_vcount)
    );

    downsample_writer i_downsample_writer (
        .clk_camera(clk_camera), .recent_reset(recent_reset),
        .pix_valid(pix_valid), .pix_data(pix_data),
        .pix_hcount(pix_hcount), .pix_vcount(pix_vcount),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    fb_arbiter i_fb_arbiter (
        .clk_camera(clk_camera), .recent_reset(recent_reset),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_pend(rd_pend), .rd_addr(rd_addr), .rd_grant(rd_grant),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    frame_buffer i_frame_buffer (
        .clk_camera(clk_camera), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    pixel_reader i_pixel_reader (
        .clk_camera(clk_camera), .recent_reset(recent_reset),
        .rd_req(rd_req), .rd_x(rd_x), .rd_y(rd_y), .chan_sel(chan_sel),
        .lower_bound(lower_bound), .upper_bound(upper_bound),
        .rd_grant(rd_grant), .mem_rdata(mem_rdata),
        .rd_pend(rd_pend), .rd_addr(rd_addr),
        .rd_valid(rd_valid), .rd_pixel(rd_pixel), .rd_mask(rd_mask)
    );

endmodule

`default_nettype wire

// ==== src/downsample_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module downsample_writer (
    input  wire                clk_camera,
    input  wire                recent_reset,
    input  wire                pix_valid,
    input  wire cam_pkg::pixel565_t pix_data,
    input  wire cam_pkg::hcount_t pix_hcount,
    input  wire cam_pkg::vcount_t pix_vcount,
    output logic               wr_en,    // single cycle write strobe
    output fb_pkg::fb_addr_t   wr_addr,
    output cam_pkg::pixel565_t wr_data
);
    import fb_pkg::*;

    fb_x_t ds_x;
    fb_y_t ds_y;
    logic  keep;

    assign ds_x = fb_x_t'(pix_hcount >> DS_SHIFT);
    assign ds_y = fb_y_t'(pix_vcount >> DS_SHIFT);

    // column and row both on the downsample grid
    assign keep = pix_valid
                  && (pix_hcount[DS_SHIFT-1:0] == '0)
                  && (pix_vcount[DS_SHIFT-1:0] == '0);

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= keep;
        end
    end

    always_ff @(posedge clk_camera) begin
        if (keep) begin
            wr_addr <= fb_addr_t'(int'(ds_x) + FB_W * int'(ds_y));  // row major
            wr_data <= pix_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/fb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
    input  wire                clk_camera,
    input  wire                recent_reset,
    input  wire                wr_en,
    input  wire fb_pkg::fb_addr_t wr_addr,
    input  wire cam_pkg::pixel565_t wr_data,
    input  wire                rd_pend,   // held until granted
    input  wire fb_pkg::fb_addr_t rd_addr,
    output logic               rd_grant,
    output logic               mem_we,
    output fb_pkg::fb_addr_t   mem_addr,
    output cam_pkg::pixel565_t mem_wdata
);
    import fb_pkg::*;

    logic [$clog2(RD_WAIT_MAX+1)-1:0] wait_cnt;  // consecutive refusals

    // capture never stalls, the write always wins the port
    assign mem_we = wr_en;
    assign mem_addr = wr_en ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;
    assign rd_grant = rd_pend & ~wr_en;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            wait_cnt <= '0;
        end else if (rd_pend && !rd_grant) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // writes come at most every 8 cycles so a read is refused briefly
    a_rd_wait: assert property (@(posedge clk_camera) disable iff (recent_reset)
        (rd_pend && !rd_grant) |-> int'(wait_cnt) < RD_WAIT_MAX)
        else $error("read starved on the frame buffer port");

endmodule

`default_nettype wire

// ==== src/fb_pkg.sv ====
`default_nettype none

// frame buffer geometry and readout codes
package fb_pkg;

    localparam int DS_SHIFT = 2;  // downsample by 1 << DS_SHIFT both ways

    localparam int FB_W = 16;
    localparam int FB_H = 8;
    localparam int FB_DEPTH = FB_W * FB_H;

    // longest run of refused cycles a pending read may see
    localparam int RD_WAIT_MAX = 2;

    typedef logic [$clog2(FB_DEPTH)-1:0] fb_addr_t;
    typedef logic [$clog2(FB_W)-1:0] fb_x_t;
    typedef logic [$clog2(FB_H)-1:0] fb_y_t;

    // channel select, code 3 falls back to green
    typedef logic [1:0] chan_sel_t;

    localparam chan_sel_t CH_GREEN = 2'd0;
    localparam chan_sel_t CH_RED = 2'd1;
    localparam chan_sel_t CH_BLUE = 2'd2;

endpackage

`default_nettype wire

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  wire                clk_camera,
    input  wire                mem_we,
    input  wire fb_pkg::fb_addr_t mem_addr,
    input  wire cam_pkg::pixel565_t mem_wdata,
    output cam_pkg::pixel565_t mem_rdata  // one cycle after the access
);
    import cam_pkg::*;
    import fb_pkg::*;

    pixel565_t mem [FB_DEPTH];

    always_ff @(posedge clk_camera) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
        mem_rdata <= mem[mem_addr];  // old data on a write cycle
    end

endmodule

`default_nettype wire

// ==== src/pixel_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_reader (
    input  wire                clk_camera,
    input  wire                recent_reset,
    input  wire                rd_req,      // host pulse
    input  wire fb_pkg::fb_x_t rd_x,
    input  wire fb_pkg::fb_y_t rd_y,
    input  wire fb_pkg::chan_sel_t chan_sel,
    input  wire [7:0]          lower_bound,
    input  wire [7:0]          upper_bound,
    input  wire                rd_grant,
    input  wire cam_pkg::pixel565_t mem_rdata,
    output logic               rd_pend,
    output fb_pkg::fb_addr_t   rd_addr,
    output logic               rd_valid,
    output cam_pkg::pixel565_t rd_pixel,
    output logic               rd_mask
);
    import cam_pkg::*;
    import fb_pkg::*;

    logic      in_flight;  // granted, data lands next cycle
    chan_sel_t sel_q;
    logic [7:0] lo_q, hi_q;
    logic [7:0] red8, green8, blue8;
    logic [7:0] chan_val;

    // widen each field to 8 bits, zeros in the low bits
    assign red8 = {mem_rdata[R_MSB:R_LSB], 3'b000};
    assign green8 = {mem_rdata[G_MSB:G_LSB], 2'b00};
    assign blue8 = {mem_rdata[B_MSB:B_LSB], 3'b000};

    always_comb begin
        case (sel_q)
            CH_GREEN: chan_val = green8;
            CH_RED:   chan_val = red8;
            CH_BLUE:  chan_val = blue8;
            default:  chan_val = green8;  // code 3 reads as green
        endcase
    end

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            rd_pend   <= 1'b0;
            in_flight <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            in_flight <= rd_grant;
            rd_valid  <= in_flight;
            if (rd_req) begin
                rd_pend <= 1'b1;
            end else if (rd_grant) begin
                rd_pend <= 1'b0;  // memory has the address now
            end
        end
    end

    always_ff @(posedge clk_camera) begin
        if (rd_req) begin
            rd_addr <= fb_addr_t'(int'(rd_x) + FB_W * int'(rd_y));
            sel_q   <= chan_sel;
            lo_q    <= lower_bound;
            hi_q    <= upper_bound;
        end
        if (in_flight) begin
            rd_pixel <= mem_rdata;
            rd_mask  <= (lo_q <= chan_val) && (chan_val <= hi_q);  // inclusive bounds
        end
    end

    a_one_req: assert property (@(posedge clk_camera) disable iff (recent_reset)
        rd_req |-> !(rd_pend || in_flight))
        else $error("host read issued before the previous one finished");

endmodule

`default_nettype wire

// ==== src/pixel_reconstruct.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_reconstruct (
    input  wire               clk_camera,
    input  wire               recent_reset,
    input  wire cam_pkg::cam_byte_t camera_d,
    input  wire               cam_pclk,
    input  wire               cam_hsync,
    input  wire               cam_vsync,
    output logic              pix_valid,   // one cycle per completed pixel
    output cam_pkg::pixel565_t pix_data,
    output cam_pkg::hcount_t  pix_hcount,
    output cam_pkg::vcount_t  pix_vcount
);
    import cam_pkg::*;

    // two flop synchronisers, pclk gets a third for edge detect
    logic      pclk_s1, pclk_s2, pclk_s3;
    logic      hs_s1, hs_s2;
    logic      vs_s1, vs_s2;
    cam_byte_t d_s1, d_s2;

    // edge detect stage, data and syncs kept in step with rise_q
    logic      rise_q;
    logic      hs_q, vs_q;
    logic      hs_prev;
    cam_byte_t d_q;

    logic      phase;      // 0 means next byte is the high byte
    cam_byte_t hi_byte;
    hcount_t   hcount;
    vcount_t   vcount;
    logic      line_seen;  // pixel emitted since hsync went high
    logic      byte_take;
    logic      pair_done;
    logic      hs_fall;

    always_ff @(posedge clk_camera) begin
        pclk_s1 <= cam_pclk;
        pclk_s2 <= pclk_s1;
        pclk_s3 <= pclk_s2;
        hs_s1   <= cam_hsync;
        hs_s2   <= hs_s1;
        vs_s1   <= cam_vsync;
        vs_s2   <= vs_s1;
        d_s1    <= camera_d;
        d_s2    <= d_s1;
        d_q     <= d_s2;   // lines up with rise_q
        hs_q    <= hs_s2;
        vs_q    <= vs_s2;
    end

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            rise_q  <= 1'b0;
            hs_prev <= 1'b0;
        end else begin
            rise_q  <= pclk_s2 & ~pclk_s3;  // registered rise of pclk
            hs_prev <= hs_q;
        end
    end

    assign byte_take = rise_q & hs_q & vs_q;  // sample only inside active video
    assign pair_done = byte_take & phase;
    assign hs_fall = hs_prev & ~hs_q;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            phase     <= 1'b0;
            hcount    <= '0;
            vcount    <= '0;
            line_seen <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= pair_done;
            if (!hs_q) begin
                // blanking, realign bytes and restart the column
                phase     <= 1'b0;
                hcount    <= '0;
                line_seen <= 1'b0;
            end else if (byte_take) begin
                phase <= ~phase;
                if (phase) begin
                    hcount    <= hcount + 1'b1;  // column after this pixel
                    line_seen <= 1'b1;
                end
            end
            // only a fall that ends a real line moves to the next row
            if (!vs_q) begin
                vcount <= '0;
            end else if (hs_fall && line_seen) begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_camera) begin
        if (byte_take && !phase) begin
            hi_byte <= d_q;  // first byte of the pair is the high half
        end
        if (pair_done) begin
            pix_data   <= {hi_byte, d_q};
            pix_hcount <= hcount;
            pix_vcount <= vcount;
        end
    end

    // hcount reaching CAM_W inside a line means more than CAM_W pixels
    a_col_range: assert property (@(posedge clk_camera) disable iff (recent_reset)
        pair_done |-> !(line_seen && hcount == hcount_t'(CAM_W)))
        else $error("camera line longer than CAM_W pixels");

endmodule

`default_nettype wire
